// File: src/piano_settings.svh
// Piano build settings
// Clock base, note and volume ranges, display and counter sizes
`ifndef PIANO_SETTINGS_SVH
`define PIANO_SETTINGS_SVH

// Half of the tone reference rate, in clock cycles per second
`define TONE_BASE 12500000

// Notes in one octave
`define NOTE_COUNT 12

// Loudest volume step
`define VOLUME_MAX 5

// LEDs in the volume bar
`define LED_COUNT 10

// Resistor paths to the speaker, quietest first
`define PATH_COUNT 5

// Half-period counter width
`define HALF_PERIOD_W 16

`endif

// File: src/toneTypesPkg.sv
// Tone types for the piano
// Note numbering, per-note period codes and half-period counts
`include "piano_settings.svh"

package toneTypesPkg;

	// A is 0 up to G-sharp at 11
	typedef logic [3:0] noteIdxT;
	typedef logic [8:0] periodCodeT;
	typedef logic [`HALF_PERIOD_W-1:0] halfPeriodT;

	// Period code of each note, a higher code gives a shorter half period
	function automatic periodCodeT noteCode(input noteIdxT idx);
		case (idx)
			4'd0: return 9'd511;
			4'd1: return 9'd482;
			4'd2: return 9'd455;
			4'd3: return 9'd430;
			4'd4: return 9'd405;
			4'd5: return 9'd383;
			4'd6: return 9'd361;
			4'd7: return 9'd341;
			4'd8: return 9'd322;
			4'd9: return 9'd303;
			4'd10: return 9'd286;
			default: return 9'd270;
		endcase
	endfunction

	// Clock cycles between wave toggles
	// One constant division per note, picked by the index
	function automatic halfPeriodT halfPeriod(input noteIdxT idx);
		halfPeriodT count;
		count = '0;
		for (int i = 0; i < `NOTE_COUNT; i++) begin
			if (idx == noteIdxT'(i))
				count = halfPeriodT'(`TONE_BASE / noteCode(noteIdxT'(i)));
		end
		return count;
	endfunction

endpackage

// File: src/panelPkg.sv
// Panel types for the piano
// Volume level, LED bar, speaker paths and note segment patterns
`include "piano_settings.svh"

package panelPkg;

	typedef logic [2:0] volumeT;
	typedef logic [`LED_COUNT-1:0] ledBarT;
	typedef logic [`PATH_COUNT-1:0] speakerPathsT;
	// Active low, dot included
	typedef logic [7:0] noteSegT;

	// Letter pattern per note, dot lit for sharps
	function automatic noteSegT noteSegments(input toneTypesPkg::noteIdxT idx,
			input logic valid);
		noteSegT seg;
		if (!valid)
			seg = '1;
		else
			case (idx)
				4'd0: seg = 8'b10000001;
				4'd1: seg = 8'b00000001;
				4'd2: seg = 8'b10011000;
				4'd3: seg = 8'b11110000;
				4'd4: seg = 8'b01110000;
				4'd5: seg = 8'b10001100;
				4'd6: seg = 8'b00001100;
				4'd7: seg = 8'b10110000;
				4'd8: seg = 8'b10110001;
				4'd9: seg = 8'b00110001;
				4'd10: seg = 8'b11010000;
				4'd11: seg = 8'b01010000;
				default: seg = '1;
			endcase
		return seg;
	endfunction

endpackage

// File: src/keyEncoder.sv
// Key encoder
// One pressed key becomes a registered note number with a valid flag
`timescale 1ns/1ps
`include "piano_settings.svh"

module keyEncoder (
	input logic clk,
	input logic rstN,
	input logic powerOn,
	input logic [11:0] keys,
	output toneTypesPkg::noteIdxT noteIdx,
	output logic noteValid
);
	import toneTypesPkg::*;

	// Key position that plays A
	localparam int A_KEY = 5;

	logic singleKey;
	noteIdxT keyNote;

	// Exactly one bit set
	assign singleKey = (keys != '0) && ((keys & (keys - 1'b1)) == '0);

	// Top key is D-sharp, notes fall toward the bottom key and wrap at A
	always_comb begin
		keyNote = '0;
		for (int i = 0; i < `NOTE_COUNT; i++) begin
			if (keys[i])
				keyNote = noteIdxT'((A_KEY - i + `NOTE_COUNT) % `NOTE_COUNT);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			noteIdx <= '0;
			noteValid <= 1'b0;
		end else begin
			noteIdx <= keyNote;
			// No note while powered down or on chords
			noteValid <= powerOn && singleKey;
		end
	end

endmodule

// File: src/volumeControl.sv
// Volume control
// Two active-low buttons step a saturating level, one step per press
`timescale 1ns/1ps
`include "piano_settings.svh"

module volumeControl (
	input logic clk,
	input logic rstN,
	input logic volUpN,
	input logic volDownN,
	output panelPkg::volumeT volume
);
	import panelPkg::*;

	// Set after a step until both buttons are let go
	logic pressLatch;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			volume <= '0;
			pressLatch <= 1'b0;
		end else if (!pressLatch && !volUpN) begin
			// Up wins when both are pressed
			if (volume < volumeT'(`VOLUME_MAX))
				volume <= volume + 1'b1;
			pressLatch <= 1'b1;
		end else if (!pressLatch && !volDownN) begin
			if (volume != '0)
				volume <= volume - 1'b1;
			pressLatch <= 1'b1;
		end else if (volUpN && volDownN) begin
			pressLatch <= 1'b0;
		end
	end

	// Level is independent of power, only reset clears it

endmodule

// File: src/toneGenerator.sv
// Tone generator
// Half-period down counter toggling a square wave for the current note
`timescale 1ns/1ps

module toneGenerator (
	input logic clk,
	input logic rstN,
	input toneTypesPkg::noteIdxT noteIdx,
	input logic noteValid,
	output logic wave
);
	import toneTypesPkg::*;

	halfPeriodT count;
	halfPeriodT reloadCount;
	noteIdxT lastNote;
	logic lastValid;
	logic noteStart;

	// Counting runs H-1 down to 0, so toggles land H cycles apart
	assign reloadCount = halfPeriod(noteIdx) - 1'b1;

	// New key press or a switch to another key
	assign noteStart = noteValid && (!lastValid || (noteIdx != lastNote));

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wave <= 1'b0;
			count <= '0;
			lastNote <= '0;
			lastValid <= 1'b0;
		end else begin
			lastNote <= noteIdx;
			lastValid <= noteValid;
			if (!noteValid) begin
				// Silent and ready for the next press
				wave <= 1'b0;
				count <= reloadCount;
			end else if (noteStart) begin
				// Restart the period, wave level is kept
				count <= reloadCount;
			end else if (count == '0) begin
				wave <= ~wave;
				count <= reloadCount;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// File: src/speakerRouter.sv
// Speaker router
// Puts the square wave on the one resistor path chosen by the volume
`timescale 1ns/1ps
`include "piano_settings.svh"

module speakerRouter (
	input logic clk,
	input logic rstN,
	input logic wave,
	input panelPkg::volumeT volume,
	output panelPkg::speakerPathsT speakerPaths
);
	import panelPkg::*;

	speakerPathsT pathNext;

	// Path 0 is the quietest and belongs to level 1
	// Level 0 matches no path and mutes
	always_comb begin
		for (int i = 0; i < `PATH_COUNT; i++)
			pathNext[i] = wave && (volume == volumeT'(i + 1));
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			speakerPaths <= '0;
		else
			speakerPaths <= pathNext;
	end

endmodule

// File: src/panelDisplay.sv
// Panel display
// Registered power dot, note letter and volume LED bar, blanked when off
`timescale 1ns/1ps
`include "piano_settings.svh"

module panelDisplay (
	input logic clk,
	input logic rstN,
	input logic powerOn,
	input toneTypesPkg::noteIdxT noteIdx,
	input logic noteValid,
	input panelPkg::volumeT volume,
	output panelPkg::ledBarT ledBar,
	output panelPkg::noteSegT noteSeg,
	output logic powerDotN
);
	import panelPkg::*;

	ledBarT ledNext;
	noteSegT segNext;

	// Two LEDs per level, filled from the top end of the bar
	always_comb begin
		for (int i = 0; i < `LED_COUNT; i++)
			ledNext[i] = (i >= `LED_COUNT - 2 * int'(volume));
	end

	// All segments dark when no single key is held
	assign segNext = noteSegments(noteIdx, noteValid);

	always_ff @(posedge clk) begin
		if (!rstN || !powerOn) begin
			// Power off looks the same as reset
			ledBar <= '0;
			noteSeg <= '1;
			powerDotN <= 1'b1;
		end else begin
			ledBar <= ledNext;
			noteSeg <= segNext;
			// Dot lit while on
			powerDotN <= 1'b0;
		end
	end

endmodule

// File: src/pianoTop.sv
// Keyboard synthesizer top level
// Keys and volume buttons in, speaker paths and panel outputs out
`timescale 1ns/1ps

module pianoTop (
	input logic clk,
	input logic rstN,
	input logic powerOn,
	input logic [11:0] keys,
	input logic volUpN,
	input logic volDownN,
	output panelPkg::speakerPathsT speakerPaths,
	output panelPkg::ledBarT ledBar,
	output panelPkg::noteSegT noteSeg,
	output logic powerDotN
);
	import toneTypesPkg::*;
	import panelPkg::*;

	noteIdxT noteIdx;
	logic noteValid;
	volumeT volume;
	logic wave;

	// Input side
	keyEncoder keyEncoder_i (
		.clk(clk),
		.rstN(rstN),
		.powerOn(powerOn),
		.keys(keys),
		.noteIdx(noteIdx),
		.noteValid(noteValid)
	);

	volumeControl volumeControl_i (
		.clk(clk),
		.rstN(rstN),
		.volUpN(volUpN),
		.volDownN(volDownN),
		.volume(volume)
	);

	// Tone
	toneGenerator toneGenerator_i (
		.clk(clk),
		.rstN(rstN),
		.noteIdx(noteIdx),
		.noteValid(noteValid),
		.wave(wave)
	);

	// Output side
	speakerRouter speakerRouter_i (
		.clk(clk),
		.rstN(rstN),
		.wave(wave),
		.volume(volume),
		.speakerPaths(speakerPaths)
	);

	panelDisplay panelDisplay_i (
		.clk(clk),
		.rstN(rstN),
		.powerOn(powerOn),
		.noteIdx(noteIdx),
		.noteValid(noteValid),
		.volume(volume),
		.ledBar(ledBar),
		.noteSeg(noteSeg),
		.powerDotN(powerDotN)
	);

endmodule

// File: sim/piano_assertions.sv
// Speaker routing checks
// At most one live path and the level in range
`timescale 1ns/1ps
`include "piano_settings.svh"

module pianoAssertions (
	input logic clk,
	input logic rstN,
	input panelPkg::volumeT volume,
	input panelPkg::speakerPathsT speakerPaths
);
	import panelPkg::*;

	// Failed checks so far
	int failCount = 0;

	onePath: assert property (@(posedge clk) disable iff (!rstN) $onehot0(speakerPaths))
		else begin
			$error("more than one speaker path is high");
			failCount++;
		end

	levelRange: assert property (@(posedge clk) disable iff (!rstN)
		volume <= volumeT'(`VOLUME_MAX))
		else begin
			$error("volume level is above its maximum");
			failCount++;
		end

endmodule

bind speakerRouter pianoAssertions pianoAssertions_i (
	.clk(clk),
	.rstN(rstN),
	.volume(volume),
	.speakerPaths(speakerPaths)
);

// File: sim/pianoTb.sv
// Keyboard synthesizer testbench
// Volume steps, note letters, tone periods, path routing and power blanking
`timescale 1ns/1ps
`include "piano_settings.svh"

module pianoTb;
	// Period codes and active-low letter patterns per note, A first
	localparam int NOTE_CODES [12] = '{511, 482, 455, 430, 405, 383, 361, 341, 322, 303,
		286, 270};
	localparam logic [7:0] NOTE_SEGS [12] = '{8'h81, 8'h01, 8'h98, 8'hf0, 8'h70, 8'h8c,
		8'h0c, 8'hb0, 8'hb1, 8'h31, 8'hd0, 8'h50};
	// Note of each key from the bottom key up, D-sharp on the top key
	localparam int KEY_NOTES [12] = '{5, 4, 3, 2, 1, 0, 11, 10, 9, 8, 7, 6};

	logic clk;
	logic rstN;
	logic powerOn;
	logic [11:0] keys;
	logic volUpN;
	logic volDownN;
	logic [4:0] speakerPaths;
	logic [9:0] ledBar;
	logic [7:0] noteSeg;
	logic powerDotN;

	int errors = 0;
	// Level the buttons should have reached
	int modelVolume = 0;
	logic pathCheckOn = 1'b0;
	logic [4:0] allowedPaths = '0;
	int keyOrder [12];

	pianoTop dut_i (.*);

	// Cycles between wave toggles for a note
	function automatic int refHalfPeriod(input int note);
		return `TONE_BASE / NOTE_CODES[note];
	endfunction

	// Three of the longest half periods, long enough for any wave to show
	function automatic int silentHoldCycles();
		int longest;
		longest = 0;
		for (int n = 0; n < `NOTE_COUNT; n++)
			if (refHalfPeriod(n) > longest)
				longest = refHalfPeriod(n);
		return 3 * longest;
	endfunction

	// Two LEDs per level, lit from the top of the bar
	function automatic logic [9:0] refLedBar(input int level);
		return 10'(((1 << (2 * level)) - 1) << (`LED_COUNT - 2 * level));
	endfunction

	// Level n drives path n-1, level 0 none
	function automatic logic [4:0] refPathMask(input int level);
		return (level == 0) ? 5'b0 : 5'(1 << (level - 1));
	endfunction

	task automatic checkValue(input string name, input int expected, input int actual);
		if (expected != actual) begin
			errors++;
			$display("error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// Two register stages, then sample between edges
	task automatic settle();
		repeat (2) @(posedge clk);
		@(negedge clk);
	endtask

	// Reset and power-off state of every output
	task automatic checkBlank();
		checkValue("speakerPaths", 0, int'(speakerPaths));
		checkValue("ledBar", 0, int'(ledBar));
		checkValue("noteSeg", 255, int'(noteSeg));
		checkValue("powerDotN", 1, int'(powerDotN));
	endtask

	// One press held for some cycles, then both buttons released
	task automatic pressButton(input logic up, input int holdCycles);
		@(negedge clk);
		if (up) begin
			volUpN = 1'b0;
			if (modelVolume < `VOLUME_MAX)
				modelVolume++;
		end else begin
			volDownN = 1'b0;
			if (modelVolume > 0)
				modelVolume--;
		end
		settle();
		checkValue("ledBar", int'(refLedBar(modelVolume)), int'(ledBar));
		repeat (holdCycles) @(negedge clk);
		// Still a single step while held
		checkValue("ledBar", int'(refLedBar(modelVolume)), int'(ledBar));
		volUpN = 1'b1;
		volDownN = 1'b1;
		repeat (3) @(negedge clk);
	endtask

	task automatic setVolume(input int level);
		while (modelVolume != level)
			pressButton(modelVolume < level, 1);
	endtask

	// Holds one key, checks its letter, then times one half period on the live path
	task automatic playNote(input int key, input int level);
		int note;
		int path;
		int cycles;
		logic last;
		note = KEY_NOTES[key];
		path = level - 1;
		setVolume(level);
		allowedPaths = refPathMask(level);
		pathCheckOn = 1'b1;
		@(negedge clk);
		keys = 12'(1 << key);
		settle();
		checkValue("noteSeg", int'(NOTE_SEGS[note]), int'(noteSeg));
		last = speakerPaths[path];
		while (speakerPaths[path] == last)
			@(negedge clk);
		last = speakerPaths[path];
		cycles = 0;
		while (speakerPaths[path] == last) begin
			@(negedge clk);
			cycles++;
		end
		checkValue("half period", refHalfPeriod(note), cycles);
		keys = '0;
		repeat (4) @(negedge clk);
		checkValue("speakerPaths", 0, int'(speakerPaths));
		pathCheckOn = 1'b0;
	endtask

	// Key pattern held over several half periods with no path allowed to move
	task automatic expectSilent(input logic [11:0] pattern, input int level, input int seg);
		setVolume(level);
		allowedPaths = '0;
		pathCheckOn = 1'b1;
		@(negedge clk);
		keys = pattern;
		settle();
		checkValue("noteSeg", seg, int'(noteSeg));
		repeat (silentHoldCycles()) @(negedge clk);
		keys = '0;
		repeat (4) @(negedge clk);
		pathCheckOn = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Only the path of the current level may carry the wave
	initial forever begin
		@(negedge clk);
		if (pathCheckOn)
			checkValue("speakerPaths", 0, int'(speakerPaths & ~allowedPaths));
	end

	// Each tone test needs at most four of its half periods
	// Four silent holds follow, plus room for the rest
	initial begin
		longint limitCycles;
		limitCycles = 200000;
		for (int n = 0; n < `NOTE_COUNT; n++)
			limitCycles += 4 * refHalfPeriod(n);
		limitCycles += 4 * silentHoldCycles();
		repeat (limitCycles) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", limitCycles);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		int pick;
		int swap;
		void'($urandom(32'h9a1));
		rstN = 1'b0;
		powerOn = 1'b0;
		keys = '0;
		volUpN = 1'b1;
		volDownN = 1'b1;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		@(negedge clk);
		checkBlank();
		powerOn = 1'b1;
		settle();
		checkValue("powerDotN", 0, int'(powerDotN));
		checkValue("noteSeg", 255, int'(noteSeg));
		// Saturate up, one long press down, saturate down
		repeat (6 + $urandom % 3)
			pressButton(1'b1, 1 + int'($urandom % 4));
		pressButton(1'b0, 40);
		repeat (6 + $urandom % 3)
			pressButton(1'b0, 1 + int'($urandom % 4));
		pressButton(1'b1, 40);
		// Shuffle the key order
		for (int i = 0; i < 12; i++)
			keyOrder[i] = i;
		for (int i = 11; i > 0; i--) begin
			pick = int'($urandom % (i + 1));
			swap = keyOrder[i];
			keyOrder[i] = keyOrder[pick];
			keyOrder[pick] = swap;
		end
		for (int i = 0; i < 12; i++)
			playNote(keyOrder[i], i % `VOLUME_MAX + 1);
		expectSilent(12'h001, 0, int'(NOTE_SEGS[KEY_NOTES[0]]));
		expectSilent(12'h003, 3, 255);
		expectSilent(12'h000, 3, 255);
		// Power off with a key held
		// No path may move, and the level comes back after power on
		allowedPaths = '0;
		pathCheckOn = 1'b1;
		keys = 12'h010;
		powerOn = 1'b0;
		repeat (silentHoldCycles()) @(negedge clk);
		checkBlank();
		pathCheckOn = 1'b0;
		powerOn = 1'b1;
		keys = '0;
		settle();
		checkValue("ledBar", int'(refLedBar(modelVolume)), int'(ledBar));
		checkValue("powerDotN", 0, int'(powerDotN));
		errors += dut_i.speakerRouter_i.pianoAssertions_i.failCount;
		$display("run complete with %0d errors", errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: project.f
+incdir+src
src/toneTypesPkg.sv
src/panelPkg.sv
src/keyEncoder.sv
src/volumeControl.sv
src/toneGenerator.sv
src/speakerRouter.sv
src/panelDisplay.sv
src/pianoTop.sv
sim/piano_assertions.sv
sim/pianoTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the piano testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f --top-module pianoTb -o pianoSim
# Assertion failures keep the run going so the testbench can report them
output=$(./obj_dir/pianoSim +verilator+error+limit+1000 || true)
echo "$output"
grep -q "NO ERRORS" <<< "$output"
